//--- logic/rcc_pkg.sv
// rcc package
// shared sizes, register map, response codes and the peripheral
// configuration word, seen either as a raw bus word or as its fields

package rcc_pkg;

  localparam int num_per = 4;
  localparam int addr_w  = 8;
  localparam int data_w  = 32;

  localparam int cfg_idx_w = $clog2(num_per);  // index into the config array

  // register map, one word per peripheral
  localparam logic [addr_w-1:0] cfg_base = 8'h10;
  localparam logic [addr_w-1:0] cfg_end  = cfg_base + addr_w'(4 * num_per);

  // clock stays gated this many bus_clk cycles after reset release
  localparam int rst_clk_delay = 2;
  localparam int rst_cnt_w     = $clog2(rst_clk_delay + 1);

  // power domain of each peripheral, 1 2 or 3
  localparam int per_domain [0:num_per-1] = '{1, 2, 3, 3};

  // axi response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // field layout, c1_en is bit 0
  typedef struct packed {
    logic [24:0] rsvd;     // kept as written
    logic        arcg_on;  // hold clock off after reset release
    logic        sft_rst;  // software reset, active high
    logic        amen;     // autonomous enable, domain 3 only
    logic        c2_lpen;
    logic        c2_en;
    logic        c1_lpen;
    logic        c1_en;
  } rcc_cfg_fields_t;

  typedef union packed {
    logic [data_w-1:0] raw;  // as stored by the register block
    rcc_cfg_fields_t   fields;
  } rcc_cfg_u;

endpackage

//--- logic/clk_gate_cell.sv
// glitch-free clock gate
// enable is captured while the clock is low, test bypass passes
// the raw clock straight through

`timescale 1ns/1ps

module clk_gate_cell (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  input  logic rst_n,
  output logic gen_clk
);

  logic en_l;

  // transparent in the low phase only
  always_latch begin
    if (!rst_n) begin
      en_l = 1'b0;
    end else if (!raw_clk) begin
      en_l = active;
    end
  end

  assign gen_clk = bypass ? raw_clk : (raw_clk & en_l);

endmodule

//--- logic/rst_release_delay.sv
// reset release clock hold
// keeps the peripheral clock enable low for a fixed number of
// bus_clk cycles after its reset goes away, when arcg_on is set

`timescale 1ns/1ps

module rst_release_delay
  import rcc_pkg::*;
(
  input  logic bus_clk,
  input  logic src_rst_n,
  input  logic arcg_on,
  output logic clk_en
);

  logic [rst_cnt_w-1:0] cnt;

  // reloads for as long as the source reset is held
  always_ff @(posedge bus_clk) begin
    if (!src_rst_n) begin
      cnt <= rst_cnt_w'(rst_clk_delay);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // hold only applies with arcg_on
  assign clk_en = !(arcg_on && (cnt != '0));

endmodule

//--- logic/per_clk_rst_control.sv
// per-peripheral clock and reset control
// combines cpu, low-power and domain-3 enables into a gated clock
// and merges system, domain and software resets

`timescale 1ns/1ps

module per_clk_rst_control
  import rcc_pkg::*;
#(
  parameter int assigned_to_cpu1 = 0,
  parameter int assigned_to_cpu2 = 0,
  parameter int support_lpen     = 0,
  parameter int support_amen     = 0,
  parameter int domain           = 1  // 1, 2 or 3
) (
  input  logic     bus_clk,
  input  logic     rst_n,
  input  logic     d1_rst_n,
  input  logic     d2_rst_n,
  input  rcc_cfg_u cfg,
  input  logic     c1_sleep,
  input  logic     c1_deepsleep,
  input  logic     c2_sleep,
  input  logic     c2_deepsleep,
  input  logic     d3_deepsleep,
  input  logic     testmode,
  output logic     per_clk,
  output logic     per_rst_n
);

  logic c1_lp_ok;
  logic c2_lp_ok;
  logic c1_path;
  logic c2_path;
  logic d3_path;
  logic clk_ok;
  logic clk_en;

  // low-power term per cpu
  assign c1_lp_ok = (support_lpen == 0) || !c1_sleep || cfg.fields.c1_lpen;
  assign c2_lp_ok = (support_lpen == 0) || !c2_sleep || cfg.fields.c2_lpen;

  // an assigned peripheral needs no en bit
  assign c1_path = ((assigned_to_cpu1 != 0) || cfg.fields.c1_en) && c1_lp_ok && !c1_deepsleep;
  assign c2_path = ((assigned_to_cpu2 != 0) || cfg.fields.c2_en) && c2_lp_ok && !c2_deepsleep;

  generate
    if (domain == 3 && support_amen != 0) begin : g_d3_amen
      assign d3_path = cfg.fields.amen && !d3_deepsleep;
    end else begin : g_d3_plain
      assign d3_path = !d3_deepsleep;
    end
  endgenerate

  assign clk_en = (c1_path || c2_path || d3_path) && clk_ok;

  // reset merge by domain
  generate
    if (domain == 1) begin : g_rst_d1
      assign per_rst_n = rst_n && d1_rst_n && !cfg.fields.sft_rst;
    end else if (domain == 2) begin : g_rst_d2
      assign per_rst_n = rst_n && d2_rst_n && !cfg.fields.sft_rst;
    end else begin : g_rst_d3
      assign per_rst_n = rst_n && !cfg.fields.sft_rst;  // no domain reset in d3
    end
  endgenerate

  rst_release_delay u_rst_release_delay (
    .bus_clk   (bus_clk),
    .src_rst_n (per_rst_n),
    .arcg_on   (cfg.fields.arcg_on),
    .clk_en    (clk_ok)
  );

  clk_gate_cell u_clk_gate_cell (
    .raw_clk (bus_clk),
    .active  (clk_en),
    .bypass  (testmode),
    .rst_n   (per_rst_n),
    .gen_clk (per_clk)
  );

endmodule

//--- logic/rcc_regs.sv
// rcc register block
// axi4-lite slave holding one configuration word per peripheral,
// one outstanding response per channel, slverr on unmapped addresses

`timescale 1ns/1ps

module rcc_regs
  import rcc_pkg::*;
(
  input  logic                      bus_clk,
  input  logic                      rst_n,

  // write address and data
  input  logic [addr_w-1:0]         awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [data_w-1:0]         wdata,
  input  logic                      wvalid,
  output logic                      wready,

  // write response
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,

  // read address and data
  input  logic [addr_w-1:0]         araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [data_w-1:0]         rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,

  output logic [num_per*data_w-1:0] cfg_words
);

  rcc_cfg_u               cfg_q [num_per];
  logic                   wr_rdy;
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   aw_hit;
  logic                   ar_hit;
  logic [cfg_idx_w-1:0]   aw_idx;
  logic [cfg_idx_w-1:0]   ar_idx;

  // word aligned and inside the config window
  function automatic logic addr_hit(input logic [addr_w-1:0] a);
    return (a[1:0] == 2'b00) && (a >= cfg_base) && (a < cfg_end);
  endfunction

  function automatic logic [cfg_idx_w-1:0] addr_idx(input logic [addr_w-1:0] a);
    logic [addr_w-1:0] off;
    off = a - cfg_base;
    return off[2 +: cfg_idx_w];
  endfunction

  assign aw_hit = addr_hit(awaddr);
  assign ar_hit = addr_hit(araddr);
  assign aw_idx = addr_idx(awaddr);
  assign ar_idx = addr_idx(araddr);

  // write channel
  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign wr_hs   = wr_rdy && awvalid && wvalid;

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      wr_rdy <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      // one cycle pulse, held off while a response waits
      wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (wr_hs) begin
      bresp <= aw_hit ? resp_okay : resp_slverr;
    end
  end

  // config storage
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      for (int n = 0; n < num_per; n++) begin
        cfg_q[n].raw <= '0;
      end
    end else if (wr_hs && aw_hit) begin
      cfg_q[aw_idx].raw <= wdata;  // whole word, no strobes
    end
  end

  // read channel
  assign rd_hs = arready && arvalid;

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rd_hs) begin
      rdata <= ar_hit ? cfg_q[ar_idx].raw : '0;  // unmapped reads as zero
      rresp <= ar_hit ? resp_okay : resp_slverr;
    end
  end

  // flatten for the top level
  always_comb begin
    for (int n = 0; n < num_per; n++) begin
      cfg_words[n*data_w +: data_w] = cfg_q[n].raw;
    end
  end

endmodule

//--- logic/rcc_top.sv
// rcc top level
// axi4-lite register block plus one clock and reset control
// per peripheral

`timescale 1ns/1ps

module rcc_top
  import rcc_pkg::*;
(
  input  logic               bus_clk,
  input  logic               rst_n,     // system reset
  input  logic               d1_rst_n,
  input  logic               d2_rst_n,

  input  logic [addr_w-1:0]  awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [data_w-1:0]  wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [addr_w-1:0]  araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [data_w-1:0]  rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,

  input  logic               c1_sleep,
  input  logic               c1_deepsleep,
  input  logic               c2_sleep,
  input  logic               c2_deepsleep,
  input  logic               d3_deepsleep,
  input  logic               testmode,

  output logic [num_per-1:0] per_clks,
  output logic [num_per-1:0] per_rst_n
);

  logic [num_per*data_w-1:0] cfg_words;

  rcc_regs u_rcc_regs (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .cfg_words (cfg_words)
  );

  // peripheral 0 belongs to cpu1, peripheral 2 has amen
  for (genvar i = 0; i < num_per; i++) begin : g_per
    per_clk_rst_control #(
      .assigned_to_cpu1 ((i == 0) ? 1 : 0),
      .assigned_to_cpu2 (0),
      .support_lpen     (1),
      .support_amen     ((i == 2) ? 1 : 0),
      .domain           (per_domain[i])
    ) u_per_ctrl (
      .bus_clk      (bus_clk),
      .rst_n        (rst_n),
      .d1_rst_n     (d1_rst_n),
      .d2_rst_n     (d2_rst_n),
      .cfg          (rcc_cfg_u'(cfg_words[i*data_w +: data_w])),
      .c1_sleep     (c1_sleep),
      .c1_deepsleep (c1_deepsleep),
      .c2_sleep     (c2_sleep),
      .c2_deepsleep (c2_deepsleep),
      .d3_deepsleep (d3_deepsleep),
      .testmode     (testmode),
      .per_clk      (per_clks[i]),
      .per_rst_n    (per_rst_n[i])
    );
  end

endmodule

//--- verif/rcc_assert.sv
// rcc protocol and clock assertions
// responses hold until accepted, peripheral clocks stay quiet
// while their reset is applied outside test mode

`timescale 1ns/1ps

module rcc_assert
  import rcc_pkg::*;
(
  input logic               bus_clk,
  input logic               rst_n,
  input logic               bvalid,
  input logic               bready,
  input logic               rvalid,
  input logic               rready,
  input logic               testmode,
  input logic [num_per-1:0] per_clks,
  input logic [num_per-1:0] per_rst_n
);

  a_bvalid_hold : assert property (@(posedge bus_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold : assert property (@(posedge bus_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // checked in the high phase, where a running clock shows
  a_clk_in_reset : assert property (@(negedge bus_clk)
    !testmode |-> ((per_clks & ~per_rst_n) == '0))
    else $error("peripheral clock running while its reset is applied");

endmodule

bind rcc_top rcc_assert u_rcc_assert (
  .bus_clk   (bus_clk),
  .rst_n     (rst_n),
  .bvalid    (bvalid),
  .bready    (bready),
  .rvalid    (rvalid),
  .rready    (rready),
  .testmode  (testmode),
  .per_clks  (per_clks),
  .per_rst_n (per_rst_n)
);

//--- verif/rcc_tb.sv
// rcc testbench
// random axi traffic, sleep and reset stimulus, checked against a
// reference model of the peripheral clock enables and resets

`timescale 1ns/1ps

module rcc_tb
  import rcc_pkg::*;
();

  localparam int clk_period = 8;
  localparam int num_txn    = 350;  // rough count of axi transactions below
  localparam int b_c1_en    = 0;
  localparam int b_c1_lpen  = 1;
  localparam int b_c2_en    = 2;
  localparam int b_c2_lpen  = 3;
  localparam int b_amen     = 4;
  localparam int b_sft_rst  = 5;

  logic bus_clk, rst_n, d1_rst_n, d2_rst_n;
  logic [addr_w-1:0] awaddr, araddr;
  logic [data_w-1:0] wdata, rdata;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;
  logic c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep, testmode;
  logic [num_per-1:0] per_clks, per_rst_n;

  logic [data_w-1:0] model_cfg [num_per];  // expected register contents
  int errors = 0;
  int checks = 0;

  rcc_top dut_i (.*);

  initial begin
    bus_clk = 1'b0;
    forever #(clk_period / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(num_txn * 40 * clk_period + 2000);
    $display("timeout, the run did not reach its end in time");
    $display("Simulation failed");
    $finish;
  end

  task automatic note_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  function automatic logic is_mapped(input logic [addr_w-1:0] a);
    int off;
    off = int'(a) - int'(cfg_base);
    return (off >= 0) && (off < 4 * num_per) && (off % 4 == 0);
  endfunction

  function automatic int word_index(input logic [addr_w-1:0] a);
    return (int'(a) - int'(cfg_base)) / 4;
  endfunction

  // peripheral 0 is tied to cpu1, peripheral 2 is the only one with amen
  function automatic logic exp_clk_en(input int n, input logic [data_w-1:0] w);
    logic c1_on, c2_on, d3_on;
    c1_on = (n == 0 || w[b_c1_en]) && (!c1_sleep || w[b_c1_lpen]) && !c1_deepsleep;
    c2_on = w[b_c2_en] && (!c2_sleep || w[b_c2_lpen]) && !c2_deepsleep;
    d3_on = (n == 2) ? (w[b_amen] && !d3_deepsleep) : !d3_deepsleep;
    return c1_on || c2_on || d3_on;
  endfunction

  function automatic logic exp_rst_n(input int n, input logic [data_w-1:0] w);
    logic dom_ok;
    case (per_domain[n])
      1:       dom_ok = d1_rst_n;
      2:       dom_ok = d2_rst_n;
      default: dom_ok = 1'b1;  // domain 3 has no domain reset
    endcase
    return rst_n && dom_ok && !w[b_sft_rst];
  endfunction

  task automatic drive_power(input logic [4:0] v);
    c1_sleep     <= v[0];
    c1_deepsleep <= v[1];
    c2_sleep     <= v[2];
    c2_deepsleep <= v[3];
    d3_deepsleep <= v[4];
  endtask

  task automatic start_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge bus_clk);
    awaddr  <= a;
    wdata   <= d;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
  endtask

  task automatic finish_write_req;
    @(negedge bus_clk);
    while (!awready) @(negedge bus_clk);
    @(posedge bus_clk);  // handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic take_write_resp(input int hold, input logic [addr_w-1:0] a);
    repeat (hold) @(posedge bus_clk);  // bready held off
    @(posedge bus_clk);
    bready <= 1'b1;
    @(negedge bus_clk);
    while (!bvalid) @(negedge bus_clk);
    checks++;
    if (bresp !== (is_mapped(a) ? resp_okay : resp_slverr)) begin
      note_error($sformatf("write to %h got bresp %b", a, bresp));
    end
    @(posedge bus_clk);
    bready <= 1'b0;
  endtask

  task automatic axi_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    start_write(a, d);
    finish_write_req();
    take_write_resp($urandom_range(0, 4), a);
    if (is_mapped(a)) begin
      model_cfg[word_index(a)] = d;
    end
  endtask

  task automatic start_read(input logic [addr_w-1:0] a);
    @(posedge bus_clk);
    araddr  <= a;
    arvalid <= 1'b1;
  endtask

  task automatic finish_read_req;
    @(negedge bus_clk);
    while (!arready) @(negedge bus_clk);
    @(posedge bus_clk);
    arvalid <= 1'b0;
  endtask

  task automatic take_read_resp(input int hold, input logic [addr_w-1:0] a);
    logic [data_w-1:0] exp_d;
    exp_d = '0;  // unmapped reads as zero
    if (is_mapped(a)) begin
      exp_d = model_cfg[word_index(a)];
    end
    repeat (hold) @(posedge bus_clk);
    @(posedge bus_clk);
    rready <= 1'b1;
    @(negedge bus_clk);
    while (!rvalid) @(negedge bus_clk);
    checks += 2;
    if (rresp !== (is_mapped(a) ? resp_okay : resp_slverr)) begin
      note_error($sformatf("read of %h got rresp %b", a, rresp));
    end
    if (rdata !== exp_d) begin
      note_error($sformatf("read of %h got %h, expected %h", a, rdata, exp_d));
    end
    @(posedge bus_clk);
    rready <= 1'b0;
  endtask

  task automatic axi_read(input logic [addr_w-1:0] a);
    start_read(a);
    finish_read_req();
    take_read_resp($urandom_range(0, 4), a);
  endtask

  // gated clocks are read 2 ns into the high phase
  task automatic check_outputs;
    logic exp_r, exp_c;
    @(posedge bus_clk);
    #2;
    for (int n = 0; n < num_per; n++) begin
      exp_r = exp_rst_n(n, model_cfg[n]);
      exp_c = exp_r && exp_clk_en(n, model_cfg[n]);
      checks += 2;
      if (per_rst_n[n] !== exp_r) begin
        note_error($sformatf("per_rst_n[%0d] is %b, expected %b", n, per_rst_n[n], exp_r));
      end
      if (per_clks[n] !== exp_c) begin
        note_error($sformatf("per_clks[%0d] is %b, expected %b", n, per_clks[n], exp_c));
      end
    end
  endtask

  task automatic check_release(input int p, input logic arcg);
    logic [data_w-1:0] held, freed;
    logic exp_c;
    held  = {25'd0, arcg, 6'b111111};  // all enables plus sft_rst
    freed = held;
    freed[b_sft_rst] = 1'b0;
    axi_write(cfg_base + 8'(4 * p), held);
    repeat (2) @(posedge bus_clk);
    check_outputs();
    fork
      axi_write(cfg_base + 8'(4 * p), freed);
      begin
        wait (per_rst_n[p] === 1'b1);
        for (int k = 1; k <= rst_clk_delay + 1; k++) begin
          @(posedge bus_clk);
          #2;
          exp_c = (arcg && k <= rst_clk_delay) ? 1'b0 : exp_clk_en(p, freed);
          checks++;
          if (per_clks[p] !== exp_c) begin
            note_error($sformatf("release hold, per_clks[%0d] cycle %0d is %b", p, k,
                                 per_clks[p]));
          end
        end
      end
    join
  endtask

  task automatic check_backpressure;
    logic [data_w-1:0] w0, w1;
    w0 = $urandom();
    w1 = $urandom();
    start_write(cfg_base, w0);
    finish_write_req();
    model_cfg[0] = w0;
    start_write(cfg_base + 8'd4, w1);  // must wait behind the pending bvalid
    repeat (6) begin
      @(negedge bus_clk);
      checks++;
      if (awready) begin
        note_error("second write accepted while bvalid waits");
      end
    end
    axi_read(cfg_base + 8'd4);  // old word still there
    take_write_resp(0, cfg_base);
    finish_write_req();
    take_write_resp(1, cfg_base + 8'd4);
    model_cfg[1] = w1;
    start_read(cfg_base + 8'd4);
    finish_read_req();
    start_read(cfg_base);
    repeat (6) begin
      @(negedge bus_clk);
      checks++;
      if (arready) begin
        note_error("second read accepted while rvalid waits");
      end
    end
    take_read_resp(0, cfg_base + 8'd4);
    finish_read_req();
    take_read_resp(2, cfg_base);
  endtask

  initial begin
    void'($urandom(32'h9c288684));
    for (int n = 0; n < num_per; n++) begin
      model_cfg[n] = '0;
    end
    rst_n    <= 1'b0;
    d1_rst_n <= 1'b1;
    d2_rst_n <= 1'b1;
    testmode <= 1'b0;
    drive_power(5'b0);
    {awaddr, awvalid, wdata, wvalid, bready} <= '0;
    {araddr, arvalid, rready} <= '0;
    repeat (9) @(posedge bus_clk);
    #2;
    checks++;
    if ({awready, wready, bvalid, arready, rvalid} !== 5'b0 || per_clks !== '0) begin
      note_error("outputs not idle during reset");
    end
    @(posedge bus_clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge bus_clk);
    check_outputs();

    // register traffic over mapped and unmapped addresses
    for (int i = 0; i < 200; i++) begin
      logic [addr_w-1:0] a;
      a = ($urandom_range(0, 1) != 0) ? cfg_base + 8'(4 * $urandom_range(0, 3))
                                      : 8'($urandom());
      if ($urandom_range(0, 1) != 0) begin
        axi_write(a, $urandom());
      end else begin
        axi_read(a);
      end
    end

    // enables and resets under random power state
    for (int i = 0; i < 30; i++) begin
      @(posedge bus_clk);
      drive_power(5'($urandom()));
      d1_rst_n <= ($urandom_range(0, 3) != 0);
      d2_rst_n <= ($urandom_range(0, 3) != 0);
      for (int n = 0; n < num_per; n++) begin
        axi_write(cfg_base + 8'(4 * n), $urandom());
      end
      repeat (2) @(posedge bus_clk);
      check_outputs();
    end

    @(posedge bus_clk);
    drive_power(5'b0);
    d1_rst_n <= 1'b1;
    d2_rst_n <= 1'b1;
    for (int p = 0; p < num_per; p++) begin
      check_release(p, 1'b1);
      check_release(p, 1'b0);
    end

    // test bypass, clocks follow bus_clk
    @(posedge bus_clk);
    testmode <= 1'b1;
    drive_power(5'($urandom()));
    for (int n = 0; n < num_per; n++) begin
      axi_write(cfg_base + 8'(4 * n), $urandom());
    end
    repeat (8) begin
      @(posedge bus_clk);
      #2;
      checks++;
      if (per_clks !== '1) begin
        note_error($sformatf("testmode high phase, per_clks is %b", per_clks));
      end
      @(negedge bus_clk);
      #2;
      checks++;
      if (per_clks !== '0) begin
        note_error($sformatf("testmode low phase, per_clks is %b", per_clks));
      end
    end
    @(posedge bus_clk);
    testmode <= 1'b0;

    check_backpressure();
    repeat (4) @(posedge bus_clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- all.f
logic/rcc_pkg.sv
logic/clk_gate_cell.sv
logic/rst_release_delay.sv
logic/per_clk_rst_control.sv
logic/rcc_regs.sv
logic/rcc_top.sv
verif/rcc_assert.sv
verif/rcc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rcc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module rcc_tb -o rcc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/rcc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
